// ==== ulpi_pkg.sv ====
`default_nettype none

// ULPI link-level constants shared by the receive path
package ulpi_pkg;

  // RX_CMD byte layout, RxEvent sits in bits 5:4
  localparam integer rxcmd_rxactive_lsb = 4;

  // RxEvent codes
  localparam logic [1:0] rx_active_code = 2'b01;
  localparam logic [1:0] rx_error_code  = 2'b11;

endpackage

`default_nettype wire

// ==== usb_pkg.sv ====
`default_nettype none

// USB 2.0 packet-level constants and CRC helpers
package usb_pkg;

  // PID group, the low two bits of the PID
  localparam logic [1:0] pid_special   = 2'b00;
  localparam logic [1:0] pid_token     = 2'b01;
  localparam logic [1:0] pid_handshake = 2'b10;
  localparam logic [1:0] pid_data      = 2'b11;

  // Token kind, PID bits 3:2 of a token group PID
  localparam logic [1:0] tok_out   = 2'b00;
  localparam logic [1:0] tok_sof   = 2'b01;
  localparam logic [1:0] tok_in    = 2'b10;
  localparam logic [1:0] tok_setup = 2'b11;

  // PING lives in the special group
  localparam logic [1:0] spc_ping = 2'b01;

  // Computed field xor received field, zero on a clean token
  localparam logic [4:0]  crc5_residue  = 5'b00000;
  localparam logic [15:0] crc16_residue = 16'h800d;
  localparam logic [15:0] crc16_init    = 16'hffff;

  // CRC5 over the 11 token bits, LSB first on the wire.
  // Returns the field in the bit order it lands in byte bits 7:3.
  function automatic logic [4:0] crc5(input logic [10:0] bits);
    logic [4:0] c;
    logic [4:0] field;
    logic       fb;
    int         i;
    c = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb = c[4] ^ bits[i];
      c  = {c[3:0], 1'b0} ^ (fb ? 5'b00101 : 5'b00000);
    end
    // Sent inverted, high register bit first
    for (i = 0; i < 5; i++) begin
      field[i] = ~c[4-i];
    end
    return field;
  endfunction

  // One byte of CRC16 (x^16 + x^15 + x^2 + 1), byte bits LSB first
  function automatic logic [15:0] crc16(input logic [7:0] data, input logic [15:0] prev);
    logic [15:0] c;
    logic        fb;
    int          i;
    c = prev;
    for (i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// ==== ulpi_rx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpi_rx_framer (
  input  logic       clock,
  input  logic       reset,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,
  output logic       byte_stb_o,
  output logic       first_stb_o,
  output logic       end_stb_o,
  output logic       busy_o,
  output logic [7:0] byte_data_o
);

  import ulpi_pkg::*;

  // Sampled ULPI bus and the dir value one cycle older
  logic       smp_dir;
  logic       smp_nxt;
  logic       prv_dir;
  logic [7:0] smp_data;

  logic       in_pkt;
  logic       rx_byte;
  logic       rx_cmd;
  logic       dir_fall;
  logic       rx_end;
  logic [1:0] rx_event;

  always_ff @(posedge clock) begin
    smp_data <= ulpi_data_i;
    if (reset) begin
      smp_dir <= 1'b0;
      smp_nxt <= 1'b0;
      prv_dir <= 1'b0;
    end else begin
      smp_dir <= ulpi_dir_i;
      smp_nxt <= ulpi_nxt_i;
      prv_dir <= smp_dir;
    end
  end

  // A turnaround cycle has prv_dir low, so it never counts as data
  assign rx_byte  = smp_dir && prv_dir && smp_nxt;
  assign rx_cmd   = smp_dir && prv_dir && !smp_nxt;
  assign dir_fall = prv_dir && !smp_dir;
  assign rx_event = smp_data[rxcmd_rxactive_lsb +: 2];

  // Inactive, error and disconnect events all close the packet
  assign rx_end = in_pkt && ((rx_cmd && rx_event != rx_active_code) || dir_fall);

  always_ff @(posedge clock) begin
    if (reset) begin
      in_pkt      <= 1'b0;
      byte_stb_o  <= 1'b0;
      first_stb_o <= 1'b0;
      end_stb_o   <= 1'b0;
    end else begin
      byte_stb_o  <= rx_byte;
      first_stb_o <= rx_byte && !in_pkt;
      end_stb_o   <= rx_end;
      if (rx_end) begin
        in_pkt <= 1'b0;
      end else if (rx_byte) begin
        in_pkt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    byte_data_o <= smp_data;
  end

  assign busy_o = in_pkt;

endmodule

`default_nettype wire

// ==== usb_pid_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_pid_decoder (
  input  logic       clock,
  input  logic       reset,
  input  logic       byte_stb_i,
  input  logic       first_stb_i,
  input  logic       end_stb_i,
  input  logic [7:0] byte_data_i,
  output logic       tok_done_o,
  output logic       sof_done_o,
  output logic       hsk_done_o,
  output logic       tok_crc_ok_o,
  output logic       pid_bad_o,
  output logic       is_data_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o
);

  import usb_pkg::*;

  logic [3:0]  pid;
  logic [1:0]  pid_grp;
  logic [1:0]  pid_kind;
  logic        pid_ok;
  logic        is_tok;
  logic        is_sof;

  // Packet class, valid from the PID until the end strobe
  logic        tok_q;
  logic        sof_q;
  logic        hsk_q;
  logic        dat_q;
  logic        bad_q;

  // Bytes seen after the PID, saturating at 3
  logic [1:0]  byte_cnt;
  logic [10:0] tok_bits;
  logic [4:0]  crc_field;
  logic        len_ok;
  logic        crc_match;

  assign pid      = byte_data_i[3:0];
  assign pid_grp  = pid[1:0];
  assign pid_kind = pid[3:2];
  assign pid_ok   = (pid == ~byte_data_i[7:4]);

  // PING carries address and endpoint just like a token
  assign is_sof = (pid_grp == pid_token) && (pid_kind == tok_sof);
  assign is_tok = ((pid_grp == pid_token) && (pid_kind != tok_sof)) ||
                  ((pid_grp == pid_special) && (pid_kind == spc_ping));

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_q    <= 1'b0;
      sof_q    <= 1'b0;
      hsk_q    <= 1'b0;
      dat_q    <= 1'b0;
      bad_q    <= 1'b0;
      byte_cnt <= 2'd0;
    end else if (first_stb_i) begin
      tok_q    <= pid_ok && is_tok;
      sof_q    <= pid_ok && is_sof;
      hsk_q    <= pid_ok && (pid_grp == pid_handshake);
      dat_q    <= (pid_grp == pid_data);
      bad_q    <= !pid_ok;
      byte_cnt <= 2'd0;
    end else if (end_stb_i) begin
      tok_q <= 1'b0;
      sof_q <= 1'b0;
      hsk_q <= 1'b0;
      dat_q <= 1'b0;
      bad_q <= 1'b0;
    end else if (byte_stb_i && byte_cnt != 2'd3) begin
      byte_cnt <= byte_cnt + 2'd1;
    end
  end

  // Address and endpoint change only on real tokens, never on SOF
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_addr_o <= 7'd0;
      tok_endp_o <= 4'd0;
    end else if (byte_stb_i && !first_stb_i && tok_q) begin
      if (byte_cnt == 2'd0) begin
        {tok_endp_o[0], tok_addr_o} <= byte_data_i;
      end else if (byte_cnt == 2'd1) begin
        tok_endp_o[3:1] <= byte_data_i[2:0];
      end
    end
  end

  // Raw 11 bits and CRC field for the CRC5 check (SOF included)
  always_ff @(posedge clock) begin
    if (byte_stb_i && !first_stb_i) begin
      if (byte_cnt == 2'd0) begin
        tok_bits[7:0] <= byte_data_i;
      end
      if (byte_cnt == 2'd1) begin
        tok_bits[10:8] <= byte_data_i[2:0];
        crc_field      <= byte_data_i[7:3];
      end
    end
  end

  assign len_ok    = (byte_cnt == 2'd2);
  assign crc_match = ((crc5(tok_bits) ^ crc_field) == crc5_residue);

  assign tok_done_o   = end_stb_i && tok_q;
  assign sof_done_o   = end_stb_i && sof_q;
  assign hsk_done_o   = end_stb_i && hsk_q;
  assign tok_crc_ok_o = end_stb_i && (tok_q || sof_q) && len_ok && crc_match;
  assign pid_bad_o    = end_stb_i && bad_q;
  assign is_data_o    = dat_q;

endmodule

`default_nettype wire

// ==== usb_crc16_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_crc16_checker (
  input  logic       clock,
  input  logic       byte_stb_i,
  input  logic       first_stb_i,
  input  logic [7:0] byte_data_i,
  input  logic       busy_i,
  output logic       crc16_ok_o
);

  import usb_pkg::*;

  logic [15:0] crc_q;

  // Seed on the PID, then fold every later byte, CRC bytes included
  always_ff @(posedge clock) begin
    if (first_stb_i) begin
      crc_q <= crc16_init;
    end else if (byte_stb_i && busy_i) begin
      crc_q <= crc16(byte_data_i, crc_q);
    end
  end

  // Running over the received CRC leaves the fixed residue
  assign crc16_ok_o = (crc_q == crc16_residue);

endmodule

`default_nettype wire

// ==== usb_rx_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_rx_result (
  input  logic       clock,
  input  logic       reset,
  input  logic       byte_stb_i,
  input  logic       first_stb_i,
  input  logic       end_stb_i,
  input  logic [7:0] byte_data_i,
  input  logic       tok_done_i,
  input  logic       sof_done_i,
  input  logic       hsk_done_i,
  input  logic       tok_crc_ok_i,
  input  logic       pid_bad_i,
  input  logic       is_data_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       crc16_ok_i,
  output logic       stream_valid_o,
  output logic       stream_keep_o,
  output logic       stream_last_o,
  output logic [3:0] stream_pid_o,
  output logic [7:0] stream_data_o,
  output logic       tok_recv_o,
  output logic       sof_recv_o,
  output logic       hsk_recv_o,
  output logic       data_recv_o,
  output logic       crc_valid_o,
  output logic       crc_error_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic       idle_o
);

  logic       open_q;
  logic       stat_q;
  logic       tok_s1;
  logic       sof_s1;
  logic       hsk_s1;
  logic       data_s1;
  logic       crc5_ok_s1;
  logic       crc16_ok_s1;
  logic [6:0] addr_s1;
  logic [3:0] endp_s1;
  logic       good_tok;
  logic       crc5_pkt;

  // Raw byte stream, the end beat carries last with keep clear
  always_ff @(posedge clock) begin
    if (reset) begin
      stream_valid_o <= 1'b0;
      stream_keep_o  <= 1'b0;
      stream_last_o  <= 1'b0;
    end else begin
      stream_valid_o <= byte_stb_i || end_stb_i;
      stream_keep_o  <= byte_stb_i;
      stream_last_o  <= end_stb_i;
    end
  end

  always_ff @(posedge clock) begin
    stream_data_o <= byte_stb_i ? byte_data_i : 8'h00;
    if (first_stb_i) begin
      stream_pid_o <= byte_data_i[3:0];
    end
  end

  // First status stage, captured alongside the end beat
  always_ff @(posedge clock) begin
    if (reset) begin
      open_q  <= 1'b0;
      stat_q  <= 1'b0;
      tok_s1  <= 1'b0;
      sof_s1  <= 1'b0;
      hsk_s1  <= 1'b0;
      data_s1 <= 1'b0;
    end else begin
      if (first_stb_i) begin
        open_q <= 1'b1;
      end else if (end_stb_i) begin
        open_q <= 1'b0;
      end
      stat_q  <= end_stb_i;
      tok_s1  <= tok_done_i;
      sof_s1  <= sof_done_i;
      hsk_s1  <= hsk_done_i;
      data_s1 <= end_stb_i && is_data_i && !pid_bad_i;
    end
  end

  always_ff @(posedge clock) begin
    crc5_ok_s1  <= tok_crc_ok_i;
    crc16_ok_s1 <= crc16_ok_i;
    addr_s1     <= tok_addr_i;
    endp_s1     <= tok_endp_i;
  end

  assign crc5_pkt = tok_s1 || sof_s1;
  assign good_tok = tok_s1 && crc5_ok_s1;

  // Second status stage drives the pulses
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_recv_o  <= 1'b0;
      sof_recv_o  <= 1'b0;
      hsk_recv_o  <= 1'b0;
      data_recv_o <= 1'b0;
      crc_valid_o <= 1'b0;
      crc_error_o <= 1'b0;
      tok_addr_o  <= 7'd0;
      tok_endp_o  <= 4'd0;
    end else begin
      tok_recv_o  <= good_tok;
      sof_recv_o  <= sof_s1 && crc5_ok_s1;
      hsk_recv_o  <= hsk_s1;
      data_recv_o <= data_s1 && crc16_ok_s1;
      crc_valid_o <= (crc5_pkt && crc5_ok_s1) || (data_s1 && crc16_ok_s1);
      crc_error_o <= (crc5_pkt && !crc5_ok_s1) || (data_s1 && !crc16_ok_s1);
      if (good_tok) begin
        tok_addr_o <= addr_s1;
        tok_endp_o <= endp_s1;
      end
    end
  end

  // Idle once no packet is open and no status is pending
  assign idle_o = !open_q && !stat_q;

endmodule

`default_nettype wire

// ==== ulpi_rx_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpi_rx_decoder (
  input  logic       clock,
  input  logic       reset,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,
  output logic       stream_valid_o,
  output logic       stream_keep_o,
  output logic       stream_last_o,
  output logic [3:0] stream_pid_o,
  output logic [7:0] stream_data_o,
  output logic       tok_recv_o,
  output logic       sof_recv_o,
  output logic       hsk_recv_o,
  output logic       data_recv_o,
  output logic       crc_valid_o,
  output logic       crc_error_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic       idle_o
);

  // Framer outputs
  logic       byte_stb;
  logic       first_stb;
  logic       end_stb;
  logic       busy;
  logic [7:0] byte_data;

  // Decoder and checker results
  logic       tok_done;
  logic       sof_done;
  logic       hsk_done;
  logic       tok_crc_ok;
  logic       pid_bad;
  logic       is_data;
  logic [6:0] tok_addr;
  logic [3:0] tok_endp;
  logic       crc16_ok;

  ulpi_rx_framer u_framer (
    .clock       (clock),
    .reset       (reset),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_i (ulpi_data_i),
    .byte_stb_o  (byte_stb),
    .first_stb_o (first_stb),
    .end_stb_o   (end_stb),
    .busy_o      (busy),
    .byte_data_o (byte_data)
  );

  usb_pid_decoder u_pid_decoder (
    .clock        (clock),
    .reset        (reset),
    .byte_stb_i   (byte_stb),
    .first_stb_i  (first_stb),
    .end_stb_i    (end_stb),
    .byte_data_i  (byte_data),
    .tok_done_o   (tok_done),
    .sof_done_o   (sof_done),
    .hsk_done_o   (hsk_done),
    .tok_crc_ok_o (tok_crc_ok),
    .pid_bad_o    (pid_bad),
    .is_data_o    (is_data),
    .tok_addr_o   (tok_addr),
    .tok_endp_o   (tok_endp)
  );

  usb_crc16_checker u_crc16 (
    .clock       (clock),
    .byte_stb_i  (byte_stb),
    .first_stb_i (first_stb),
    .byte_data_i (byte_data),
    .busy_i      (busy),
    .crc16_ok_o  (crc16_ok)
  );

  usb_rx_result u_result (
    .clock          (clock),
    .reset          (reset),
    .byte_stb_i     (byte_stb),
    .first_stb_i    (first_stb),
    .end_stb_i      (end_stb),
    .byte_data_i    (byte_data),
    .tok_done_i     (tok_done),
    .sof_done_i     (sof_done),
    .hsk_done_i     (hsk_done),
    .tok_crc_ok_i   (tok_crc_ok),
    .pid_bad_i      (pid_bad),
    .is_data_i      (is_data),
    .tok_addr_i     (tok_addr),
    .tok_endp_i     (tok_endp),
    .crc16_ok_i     (crc16_ok),
    .stream_valid_o (stream_valid_o),
    .stream_keep_o  (stream_keep_o),
    .stream_last_o  (stream_last_o),
    .stream_pid_o   (stream_pid_o),
    .stream_data_o  (stream_data_o),
    .tok_recv_o     (tok_recv_o),
    .sof_recv_o     (sof_recv_o),
    .hsk_recv_o     (hsk_recv_o),
    .data_recv_o    (data_recv_o),
    .crc_valid_o    (crc_valid_o),
    .crc_error_o    (crc_error_o),
    .tok_addr_o     (tok_addr_o),
    .tok_endp_o     (tok_endp_o),
    .idle_o         (idle_o)
  );

endmodule

`default_nettype wire

// ==== ulpi_rx_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ulpi_rx_assert (
  input logic clock,
  input logic reset,
  input logic stream_keep_i,
  input logic stream_last_i,
  input logic tok_recv_i,
  input logic sof_recv_i,
  input logic hsk_recv_i,
  input logic data_recv_i,
  input logic crc_valid_i,
  input logic crc_error_i
);

  logic [5:0] pulses;

  assign pulses = {tok_recv_i, sof_recv_i, hsk_recv_i, data_recv_i, crc_valid_i, crc_error_i};

  // One packet type per status beat, and never both CRC flags
  a_pulse_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(pulses[5:2]) && !(crc_valid_i && crc_error_i))
    else $error("status pulses not one-hot");

  a_last_no_keep: assert property (@(posedge clock) disable iff (reset)
    stream_last_i |-> !stream_keep_i)
    else $error("end beat carries keep");

  a_reset_quiet: assert property (@(posedge clock)
    (reset && $past(reset)) |-> (pulses == 6'd0))
    else $error("status pulse during reset");

endmodule

bind ulpi_rx_decoder ulpi_rx_assert u_assert (
  .clock         (clock),
  .reset         (reset),
  .stream_keep_i (stream_keep_o),
  .stream_last_i (stream_last_o),
  .tok_recv_i    (tok_recv_o),
  .sof_recv_i    (sof_recv_o),
  .hsk_recv_i    (hsk_recv_o),
  .data_recv_i   (data_recv_o),
  .crc_valid_i   (crc_valid_o),
  .crc_error_i   (crc_error_o)
);

`default_nettype wire

// ==== tb_ulpi_rx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ulpi_rx_checker (
  input  logic       clock,
  input  logic       start_i,
  input  logic       idle_check_i,
  input  int         test_id_i,
  input  logic [5:0] exp_pulses_i,
  input  logic [6:0] exp_addr_i,
  input  logic [3:0] exp_endp_i,
  input  int         exp_len_i,
  input  logic [7:0] exp_bytes_i [0:15],
  input  logic       stream_valid_i,
  input  logic       stream_keep_i,
  input  logic       stream_last_i,
  input  logic [3:0] stream_pid_i,
  input  logic [7:0] stream_data_i,
  input  logic       tok_recv_i,
  input  logic       sof_recv_i,
  input  logic       hsk_recv_i,
  input  logic       data_recv_i,
  input  logic       crc_valid_i,
  input  logic       crc_error_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       idle_i,
  output int         done_count_o,
  output int         err_count_o
);

  function automatic string pulse_name(input int k);
    case (k)
      5: return "tok_recv_o";
      4: return "sof_recv_o";
      3: return "hsk_recv_o";
      2: return "data_recv_o";
      1: return "crc_valid_o";
      default: return "crc_error_o";
    endcase
  endfunction

  task automatic show_error(input string name, input int exp_val, input int got_val);
    $display("** Error at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
    err_count_o++;
  endtask

  task automatic run_check();
    int         cycles;
    int         beat;
    int         tail;
    int         errs_before;
    int         k;
    int         cnt [0:5];
    logic       seen_last;
    logic       finished;
    logic [5:0] pulses;
    cycles      = 0;
    beat        = 0;
    tail        = 0;
    seen_last   = 1'b0;
    finished    = 1'b0;
    errs_before = err_count_o;
    for (k = 0; k < 6; k++) begin
      cnt[k] = 0;
    end
    while (!finished && cycles < 300) begin
      @(negedge clock);
      cycles++;
      pulses = {tok_recv_i, sof_recv_i, hsk_recv_i, data_recv_i, crc_valid_i, crc_error_i};
      for (k = 0; k < 6; k++) begin
        if (pulses[k]) begin
          cnt[k]++;
        end
      end
      if (idle_check_i) begin
        if (!idle_i) begin
          show_error("idle_o", 1, 0);
        end
        if (stream_valid_i) begin
          show_error("stream_valid_o", 0, 1);
        end
        finished = (cycles >= 10);
      end else begin
        if (stream_valid_i && stream_keep_i) begin
          if (beat < exp_len_i && stream_data_i != exp_bytes_i[beat]) begin
            show_error("stream_data_o", int'(exp_bytes_i[beat]), int'(stream_data_i));
          end
          beat++;
        end
        if (stream_valid_i && stream_last_i) begin
          seen_last = 1'b1;
          if (stream_pid_i != exp_bytes_i[0][3:0]) begin
            show_error("stream_pid_o", int'(exp_bytes_i[0][3:0]), int'(stream_pid_i));
          end
        end else if (seen_last) begin
          // Status lands one cycle after the end beat
          tail++;
          finished = (tail >= 3);
        end
      end
    end
    if (!finished) begin
      $display("Test %0d: no end of packet seen before the timeout", test_id_i);
      err_count_o++;
    end
    if (!idle_check_i && beat != exp_len_i) begin
      show_error("stream byte count", exp_len_i, beat);
    end
    for (k = 0; k < 6; k++) begin
      if (cnt[k] != int'(exp_pulses_i[k])) begin
        show_error(pulse_name(k), int'(exp_pulses_i[k]), cnt[k]);
      end
    end
    if (tok_addr_i != exp_addr_i) begin
      show_error("tok_addr_o", int'(exp_addr_i), int'(tok_addr_i));
    end
    if (tok_endp_i != exp_endp_i) begin
      show_error("tok_endp_o", int'(exp_endp_i), int'(tok_endp_i));
    end
    if (err_count_o == errs_before) begin
      $display("Test %0d: ok", test_id_i);
    end else begin
      $display("Test %0d: FAILED", test_id_i);
    end
  endtask

  initial begin
    done_count_o = 0;
    err_count_o  = 0;
    forever begin
      @(negedge clock);
      if (start_i) begin
        run_check();
        done_count_o++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_ulpi_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ulpi_rx;

  import usb_pkg::*;
  import ulpi_pkg::*;

  logic       clock;
  logic       reset;
  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic [7:0] ulpi_data;
  logic       stream_valid;
  logic       stream_keep;
  logic       stream_last;
  logic [3:0] stream_pid;
  logic [7:0] stream_data;
  logic       tok_recv;
  logic       sof_recv;
  logic       hsk_recv;
  logic       data_recv;
  logic       crc_valid;
  logic       crc_error;
  logic [6:0] tok_addr;
  logic [3:0] tok_endp;
  logic       idle;

  // Packet under test and its expectation
  logic [7:0] pkt [0:15];
  int         pkt_len;
  logic       start;
  logic       idle_check;
  int         test_id;
  logic [5:0] exp_pulses;
  logic [6:0] exp_addr;
  logic [3:0] exp_endp;
  int         done_count;
  int         err_count;
  logic       timed_out;
  logic [31:0] r;

  ulpi_rx_decoder ulpi_rx_decoder_i (
    .clock          (clock),
    .reset          (reset),
    .ulpi_dir_i     (ulpi_dir),
    .ulpi_nxt_i     (ulpi_nxt),
    .ulpi_data_i    (ulpi_data),
    .stream_valid_o (stream_valid),
    .stream_keep_o  (stream_keep),
    .stream_last_o  (stream_last),
    .stream_pid_o   (stream_pid),
    .stream_data_o  (stream_data),
    .tok_recv_o     (tok_recv),
    .sof_recv_o     (sof_recv),
    .hsk_recv_o     (hsk_recv),
    .data_recv_o    (data_recv),
    .crc_valid_o    (crc_valid),
    .crc_error_o    (crc_error),
    .tok_addr_o     (tok_addr),
    .tok_endp_o     (tok_endp),
    .idle_o         (idle)
  );

  tb_ulpi_rx_checker u_checker (
    .clock          (clock),
    .start_i        (start),
    .idle_check_i   (idle_check),
    .test_id_i      (test_id),
    .exp_pulses_i   (exp_pulses),
    .exp_addr_i     (exp_addr),
    .exp_endp_i     (exp_endp),
    .exp_len_i      (pkt_len),
    .exp_bytes_i    (pkt),
    .stream_valid_i (stream_valid),
    .stream_keep_i  (stream_keep),
    .stream_last_i  (stream_last),
    .stream_pid_i   (stream_pid),
    .stream_data_i  (stream_data),
    .tok_recv_i     (tok_recv),
    .sof_recv_i     (sof_recv),
    .hsk_recv_i     (hsk_recv),
    .data_recv_i    (data_recv),
    .crc_valid_i    (crc_valid),
    .crc_error_i    (crc_error),
    .tok_addr_i     (tok_addr),
    .tok_endp_i     (tok_endp),
    .idle_i         (idle),
    .done_count_o   (done_count),
    .err_count_o    (err_count)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #4 clock = ~clock;
    end
  end

  // USB CRC5, poly x^5+x^2+1, field sent inverted, high bit first
  function automatic logic [4:0] ref_crc5(input logic [10:0] bits);
    logic [4:0] c;
    logic [4:0] field;
    logic       fb;
    c = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      fb = c[4] ^ bits[i];
      c  = {c[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
    end
    for (int i = 0; i < 5; i++) begin
      field[i] = ~c[4-i];
    end
    return field;
  endfunction

  // USB CRC16 step, poly x^16+x^15+x^2+1, byte LSB first
  function automatic logic [15:0] ref_crc16(input logic [7:0] data, input logic [15:0] prev);
    logic [15:0] c;
    logic        fb;
    c = prev;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
    end
    return c;
  endfunction

  // Expected {tok, sof, hsk, data, crc_valid, crc_error} for the current packet
  function logic [5:0] ref_outcome();
    logic [3:0]  pid;
    logic        ok;
    logic [15:0] c;
    pid = pkt[0][3:0];
    if (pkt[0][7:4] != ~pid) begin
      return 6'b000000;
    end
    if (pid[1:0] == pid_token || (pid[1:0] == pid_special && pid[3:2] == spc_ping)) begin
      ok = (pkt_len == 3) && (ref_crc5({pkt[2][2:0], pkt[1]}) == pkt[2][7:3]);
      if (pid[1:0] == pid_token && pid[3:2] == tok_sof) begin
        return {1'b0, ok, 2'b00, ok, !ok};
      end
      return {ok, 3'b000, ok, !ok};
    end
    if (pid[1:0] == pid_handshake) begin
      return 6'b001000;
    end
    if (pid[1:0] == pid_data) begin
      c = crc16_init;
      for (int i = 1; i < pkt_len; i++) begin
        c = ref_crc16(pkt[i], c);
      end
      ok = (c == crc16_residue);
      return {3'b000, ok, ok, !ok};
    end
    return 6'b000000;
  endfunction

  task automatic drive(input logic dir, input logic nxt, input logic [7:0] data);
    @(posedge clock);
    #1;
    ulpi_dir  = dir;
    ulpi_nxt  = nxt;
    ulpi_data = data;
  endtask

  // PHY model: turnaround, bytes with RX_CMD gaps, end RX_CMD, dir low
  task automatic send_packet();
    logic [7:0] active_cmd;
    logic [31:0] g;
    active_cmd = 8'h00;
    active_cmd[rxcmd_rxactive_lsb +: 2] = rx_active_code;
    drive(1'b1, 1'b1, 8'h00);
    for (int i = 0; i < pkt_len; i++) begin
      g = $urandom();
      if (g[1:0] == 2'b00) begin
        drive(1'b1, 1'b0, active_cmd);
      end
      drive(1'b1, 1'b1, pkt[i]);
    end
    drive(1'b1, 1'b0, 8'h00);
    drive(1'b0, 1'b0, 8'h00);
  endtask

  task automatic build_data(input logic [3:0] pid, input int n);
    logic [15:0] c;
    logic [31:0] v;
    pkt[0] = {~pid, pid};
    c = crc16_init;
    for (int i = 1; i <= n; i++) begin
      v = $urandom();
      pkt[i] = v[7:0];
      c = ref_crc16(pkt[i], c);
    end
    for (int i = 0; i < 8; i++) begin
      pkt[n+1][i] = ~c[15-i];
      pkt[n+2][i] = ~c[7-i];
    end
    pkt_len = n + 3;
  endtask

  task automatic build_token(input logic [3:0] pid, input logic [10:0] bits);
    pkt[0]  = {~pid, pid};
    pkt[1]  = bits[7:0];
    pkt[2]  = {ref_crc5(bits), bits[10:8]};
    pkt_len = 3;
  endtask

  task automatic run_test(input logic chk_idle);
    int target;
    int cycles;
    if (!timed_out) begin
      test_id++;
      exp_pulses = chk_idle ? 6'b000000 : ref_outcome();
      if (exp_pulses[5]) begin
        exp_addr = pkt[1][6:0];
        exp_endp = {pkt[2][2:0], pkt[1][7]};
      end
      target = done_count + 1;
      @(posedge clock);
      #1;
      idle_check = chk_idle;
      start      = 1'b1;
      @(posedge clock);
      #1;
      start = 1'b0;
      if (!chk_idle) begin
        send_packet();
      end
      cycles = 0;
      while (done_count < target && cycles < 400) begin
        @(posedge clock);
        cycles++;
      end
      if (done_count < target) begin
        $display("Timeout: checker did not finish test %0d", test_id);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    reset      = 1'b1;
    ulpi_dir   = 1'b0;
    ulpi_nxt   = 1'b0;
    ulpi_data  = 8'h00;
    start      = 1'b0;
    idle_check = 1'b0;
    test_id    = 0;
    pkt_len    = 0;
    exp_pulses = 6'd0;
    exp_addr   = 7'd0;
    exp_endp   = 4'd0;
    timed_out  = 1'b0;
    for (int i = 0; i < 16; i++) begin
      pkt[i] = 8'h00;
    end
    r = $urandom(32'hc8e3db78);
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    run_test(1'b1);

    // Data packets, clean then with one payload bit flipped
    for (int t = 0; t < 4; t++) begin
      r = $urandom();
      build_data({r[0], 1'b0, pid_data}, 1 + int'(r[11:8]) % 8);
      run_test(1'b0);
      pkt[1 + int'(r[23:16]) % (pkt_len - 3)][r[26:24]] ^= 1'b1;
      run_test(1'b0);
    end

    // OUT, IN, SETUP, PING
    for (int t = 0; t < 4; t++) begin
      r = $urandom();
      case (t)
        0: build_token({tok_out, pid_token}, r[10:0]);
        1: build_token({tok_in, pid_token}, r[10:0]);
        2: build_token({tok_setup, pid_token}, r[10:0]);
        default: build_token({spc_ping, pid_special}, r[10:0]);
      endcase
      run_test(1'b0);
    end

    // SOF clean, then with a corrupted CRC5 field
    r = $urandom();
    build_token({tok_sof, pid_token}, r[10:0]);
    run_test(1'b0);
    pkt[2][5] ^= 1'b1;
    run_test(1'b0);

    // ACK, NAK, STALL
    pkt_len = 1;
    pkt[0] = {~{2'b00, pid_handshake}, 2'b00, pid_handshake};
    run_test(1'b0);
    pkt[0] = {~{2'b10, pid_handshake}, 2'b10, pid_handshake};
    run_test(1'b0);
    pkt[0] = {~{2'b11, pid_handshake}, 2'b11, pid_handshake};
    run_test(1'b0);

    // Check nibble equal to the PID itself
    pkt[0] = 8'h22;
    run_test(1'b0);
    r = $urandom();
    build_token({tok_in, pid_token}, r[10:0]);
    pkt[0] = 8'h99;
    run_test(1'b0);
    // Data group with a clean payload CRC
    r = $urandom();
    build_data({1'b1, 1'b0, pid_data}, 1 + int'(r[11:8]) % 8);
    pkt[0] = 8'hbb;
    run_test(1'b0);

    $display("Tests run %0d, errors %0d", test_id, err_count);
    if (!timed_out && err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_rx.f ====
ulpi_pkg.sv
usb_pkg.sv
ulpi_rx_framer.sv
usb_pid_decoder.sv
usb_crc16_checker.sv
usb_rx_result.sv
ulpi_rx_decoder.sv
ulpi_rx_assert.sv
tb_ulpi_rx_checker.sv
tb_ulpi_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f usb_rx.f --top-module tb_ulpi_rx -o tb_ulpi_rx_sim

out=$(./obj_dir/tb_ulpi_rx_sim)
echo "$out"
echo "$out" | grep -q "Verification passed"
